//--- vlog.f
+incdir+sim
hw/vdp_pkg.sv
hw/vdp_cpu_port.sv
hw/vdp_beam_timing.sv
hw/vdp_interrupt.sv
hw/vdp_top.sv
sim/tb_vdp.sv

//--- Bender.yml
package:
  name: vdp_host_core

sources:
  - hw/vdp_pkg.sv
  - hw/vdp_cpu_port.sv
  - hw/vdp_beam_timing.sv
  - hw/vdp_interrupt.sv
  - hw/vdp_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_vdp.sv

//--- sim/tb_vdp_tasks.svh
// ----------------------------------------------------------
// VDP testbench tasks
// Bus access, compare helpers and the directed tests
// ----------------------------------------------------------

`ifndef TB_VDP_TASKS_SVH
`define TB_VDP_TASKS_SVH

  // ----------------------------------------------------------
  // Bus access
  // ----------------------------------------------------------
  task automatic wb_cycle(input logic wr, input port_addr_t a, input vdp_byte_t d,
                          output vdp_byte_t rd);
    int n;
    n = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    @(negedge clk);
    while (!ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      abort_run("the DUT never raised ack");
    end
    rd = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_write(input port_addr_t a, input vdp_byte_t d);
    vdp_byte_t unused;
    wb_cycle(1'b1, a, d, unused);
  endtask

  task automatic wb_read(input port_addr_t a, output vdp_byte_t rd);
    wb_cycle(1'b0, a, 8'h00, rd);
  endtask

  // Data byte first, then register number with bit 7 set
  task automatic write_reg(input reg_num_t num, input vdp_byte_t val);
    wb_write(port_addr_t'(1), val);
    wb_write(port_addr_t'(1), {2'b10, num});
  endtask

  task automatic read_status(input status_sel_t sel, output vdp_byte_t val);
    write_reg(REG_STATUS_PTR, {4'h0, sel});
    wb_read(port_addr_t'(1), val);
  endtask

  // Returns the cycle count at the first low sample
  task automatic wait_int_fall(output int at_cycle);
    int n;
    n = 0;
    @(negedge clk);
    while (int_n && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (int_n) begin
      abort_run("int_n never went low");
    end
    at_cycle = cycle_cnt;
  endtask

  // ----------------------------------------------------------
  // Compare and report
  // ----------------------------------------------------------
  task automatic cmp_byte(input string what, input vdp_byte_t exp, input vdp_byte_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      test_errs++;
      $display("FAIL %s %s expected 0x%02h actual 0x%02h", cur_test, what, exp, act);
    end
  endtask

  task automatic cmp_bit(input string what, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      test_errs++;
      $display("FAIL %s %s expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic cmp_count(input string what, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      err_cnt++;
      test_errs++;
      $display("FAIL %s %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs != 0) begin
      bad_tests++;
    end
    $display("%-16s %0d errors", cur_test, test_errs);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    vdp_byte_t rd;
    begin_test("reset_state");
    @(negedge clk);
    cmp_bit("int_n", 1'b1, int_n);
    wb_read(port_addr_t'(1), rd);
    cmp_byte("S0", 8'h00, rd);
    end_test();
  endtask

  task automatic test_vblank_irq();
    vdp_byte_t rd;
    int        t;
    begin_test("vblank_irq");
    write_reg(REG_MODE1, vdp_byte_t'(1 << R1_IE0_BIT));
    wait_int_fall(t);
    read_status(4'd0, rd);
    cmp_byte("S0 pending", 8'h80, rd);
    @(negedge clk);
    cmp_bit("int_n after S0 read", 1'b1, int_n);
    read_status(4'd0, rd);
    cmp_byte("S0 cleared", 8'h00, rd);
    end_test();
  endtask

  task automatic test_masked_vblank();
    vdp_byte_t rd;
    logic      low_seen;
    begin_test("masked_vblank");
    write_reg(REG_MODE1, 8'h00);
    low_seen = 1'b0;
    // One NTSC frame plus a line
    repeat (263 * 342) begin
      @(negedge clk);
      if (!int_n) begin
        low_seen = 1'b1;
      end
    end
    cmp_bit("int_n fell while masked", 1'b0, low_seen);
    read_status(4'd0, rd);
    cmp_byte("S0 pending", 8'h80, rd);
    end_test();
  endtask

  task automatic test_line_irq();
    vdp_byte_t rd;
    vdp_byte_t line;
    int        t;
    begin_test("line_irq");
    line = vdp_byte_t'((next_random() >> 8) % 192);
    write_reg(REG_INT_LINE, line);
    // Flag may be left over from earlier frames on line 0
    read_status(4'd1, rd);
    write_reg(REG_MODE0, vdp_byte_t'(1 << R0_IE1_BIT));
    wait_int_fall(t);
    read_status(4'd1, rd);
    cmp_byte("S1 pending", 8'h01, rd);
    // Still inside horizontal blank of an active line
    read_status(4'd2, rd);
    cmp_byte("S2 blanking", 8'h20, rd);
    read_status(4'd1, rd);
    cmp_byte("S1 cleared", 8'h00, rd);
    write_reg(REG_MODE0, 8'h00);
    end_test();
  endtask

  task automatic test_pal_frame();
    vdp_byte_t rd;
    int        t0;
    int        t1;
    begin_test("pal_frame");
    write_reg(REG_MODE9, vdp_byte_t'(1 << R9_NT_BIT));
    read_status(4'd0, rd);
    write_reg(REG_MODE1, vdp_byte_t'(1 << R1_IE0_BIT));
    wait_int_fall(t0);
    read_status(4'd0, rd);
    cmp_byte("S0 first", 8'h80, rd);
    wait_int_fall(t1);
    cmp_count("frame cycles", 313 * 342, t1 - t0);
    read_status(4'd0, rd);
    cmp_byte("S0 second", 8'h80, rd);
    end_test();
  endtask

  task automatic test_ignored_writes();
    vdp_byte_t rd;
    int        t;
    begin_test("ignored_writes");
    // Would disable IE0 or move the status pointer if decoded
    write_reg(reg_num_t'(7), 8'h0F);
    wait_int_fall(t);
    wb_read(port_addr_t'(1), rd);
    cmp_byte("S0 after R7 write", 8'h80, rd);
    @(negedge clk);
    cmp_bit("int_n after S0 read", 1'b1, int_n);
    read_status(4'd9, rd);
    cmp_byte("unused status 9", 8'hFF, rd);
    wb_read(port_addr_t'(0), rd);
    cmp_byte("port 0 read", 8'hFF, rd);
    end_test();
  endtask

`endif

//--- sim/tb_vdp.sv
// ----------------------------------------------------------
// VDP host core testbench
// Directed tests through the Wishbone control port
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_vdp
  import vdp_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // Longest wait is one PAL frame plus margin
  localparam int WAIT_LIMIT = 120000;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  port_addr_t  adr;
  vdp_byte_t   dat_w;
  vdp_byte_t   dat_r;
  logic        ack;
  logic        int_n;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  string       cur_test;
  int          test_errs;
  int          bad_tests;
  int          check_cnt;
  int          err_cnt;
  event        abort_ev;

  // RESET is the clock and CLK21M the reset on this core
  vdp_top u_vdp_top (
    .RESET  (clk),
    .CLK21M (rst),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack),
    .int_n  (int_n)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Free-running cycle count for interval checks
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Ends the run once a timeout has been reported
  initial begin
    @(abort_ev);
    $finish;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string reason);
    $display("ERROR in %s: %s", cur_test, reason);
    $display("Checks: %0d, check errors: %0d", check_cnt, err_cnt + 1);
    $display("Testbench failed");
    -> abort_ev;
    @(posedge clk);
  endtask

  `include "tb_vdp_tasks.svh"

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    rst       = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    lcg_state = 32'h0a79_d670;
    cur_test  = "reset";
    test_errs = 0;
    bad_tests = 0;
    check_cnt = 0;
    err_cnt   = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    test_reset_state();
    test_vblank_irq();
    test_masked_vblank();
    test_line_irq();
    test_pal_frame();
    test_ignored_writes();

    $display("Tests: 6, tests with errors: %0d, checks: %0d, check errors: %0d",
             bad_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- hw/vdp_top.sv
// ----------------------------------------------------------
// VDP host core top level
// Joins the CPU port, beam timing and interrupt unit
// ----------------------------------------------------------

`timescale 1ns/10ps

module vdp_top
  import vdp_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  port_addr_t adr,
  input  vdp_byte_t  dat_w,
  output vdp_byte_t  dat_r,
  output logic       ack,
  output logic       int_n
);

  vdp_ctrl_t  ctrl;
  beam_t      beam;
  int_flags_t flags;
  logic       clr_vblank;
  logic       clr_line;
  logic       vblank_start;
  logic       line_match;

  // Host bus and registers
  vdp_cpu_port u_cpu_port (
    .RESET      (RESET),
    .CLK21M     (CLK21M),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .beam       (beam),
    .flags      (flags),
    .dat_r      (dat_r),
    .ack        (ack),
    .ctrl       (ctrl),
    .clr_vblank (clr_vblank),
    .clr_line   (clr_line)
  );

  vdp_beam_timing u_beam_timing (
    .RESET        (RESET),
    .CLK21M       (CLK21M),
    .ctrl         (ctrl),
    .beam         (beam),
    .vblank_start (vblank_start),
    .line_match   (line_match)
  );

  vdp_interrupt u_interrupt (
    .RESET        (RESET),
    .CLK21M       (CLK21M),
    .ctrl         (ctrl),
    .vblank_start (vblank_start),
    .line_match   (line_match),
    .clr_vblank   (clr_vblank),
    .clr_line     (clr_line),
    .flags        (flags),
    .int_n        (int_n)
  );

endmodule

//--- hw/vdp_interrupt.sv
// ----------------------------------------------------------
// VDP interrupt unit
// Pending flags for vertical blank and line match, masked
// onto the active-low interrupt line
// ----------------------------------------------------------

`timescale 1ns/10ps

module vdp_interrupt
  import vdp_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  vdp_ctrl_t  ctrl,
  input  logic       vblank_start,
  input  logic       line_match,
  input  logic       clr_vblank,
  input  logic       clr_line,
  output int_flags_t flags,
  output logic       int_n
);

  logic vblank_req;
  logic line_req;

  // ----------------------------------------------------------
  // Pending flags
  // ----------------------------------------------------------
  // An event in the same cycle as a clear keeps the flag set
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      flags <= '0;
    end else begin
      if (vblank_start) begin
        flags.vblank_pend <= 1'b1;
      end else if (clr_vblank) begin
        flags.vblank_pend <= 1'b0;
      end

      if (line_match) begin
        flags.line_pend <= 1'b1;
      end else if (clr_line) begin
        flags.line_pend <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Interrupt output
  // ----------------------------------------------------------
  // Flags are set regardless of the enables; only the pin is masked
  assign vblank_req = flags.vblank_pend & ctrl.vblank_int_en;
  assign line_req   = flags.line_pend & ctrl.line_int_en;

  assign int_n = ~(vblank_req | line_req);

endmodule

//--- hw/vdp_beam_timing.sv
// ----------------------------------------------------------
// VDP beam timing
// Dot and line counters, blanking flags and interrupt events
// ----------------------------------------------------------

`timescale 1ns/10ps

module vdp_beam_timing
  import vdp_pkg::*;
(
  input  logic      RESET,
  input  logic      CLK21M,
  input  vdp_ctrl_t ctrl,
  output beam_t     beam,
  output logic      vblank_start,
  output logic      line_match
);

  dot_cnt_t  dot_q;
  line_cnt_t line_q;
  line_cnt_t frame_lines;
  line_cnt_t active_lines;
  logic      dot_wrap;
  logic      line_wrap;

  // ----------------------------------------------------------
  // Frame format
  // ----------------------------------------------------------
  assign frame_lines  = ctrl.pal_mode ? LINES_PAL : LINES_NTSC;
  assign active_lines = ctrl.lines_212 ? ACTIVE_LINES_212 : ACTIVE_LINES_192;

  assign dot_wrap = (dot_q == DOTS_PER_LINE - 9'd1);

  // Greater-or-equal also covers a switch from PAL to NTSC
  // while the beam is past line 261
  assign line_wrap = (line_q >= frame_lines - 9'd1);

  // ----------------------------------------------------------
  // Counters
  // ----------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dot_q  <= '0;
      line_q <= '0;
    end else begin
      if (dot_wrap) begin
        dot_q <= '0;
        if (line_wrap) begin
          line_q <= '0;
        end else begin
          line_q <= line_q + 9'd1;
        end
      end else begin
        dot_q <= dot_q + 9'd1;
      end
    end
  end

  // ----------------------------------------------------------
  // Beam position and blanking
  // ----------------------------------------------------------
  always_comb begin
    beam.dot    = dot_q;
    beam.line   = line_q;
    beam.hblank = (dot_q >= ACTIVE_DOTS);
    beam.vblank = (line_q >= active_lines);
  end

  // First dot of the first blanked line
  assign vblank_start = (dot_q == '0) && (line_q == active_lines);

  // Line interrupt fires at the start of horizontal blank
  assign line_match = (dot_q == ACTIVE_DOTS) && (line_q == {1'b0, ctrl.int_line});

endmodule

//--- hw/vdp_cpu_port.sv
// ----------------------------------------------------------
// VDP CPU port
// Wishbone slave for the two-byte control port, control
// registers and the status read path
// ----------------------------------------------------------

`timescale 1ns/10ps

module vdp_cpu_port
  import vdp_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  port_addr_t adr,
  input  vdp_byte_t  dat_w,
  input  beam_t      beam,
  input  int_flags_t flags,
  output vdp_byte_t  dat_r,
  output logic       ack,
  output vdp_ctrl_t  ctrl,
  output logic       clr_vblank,
  output logic       clr_line
);

  port_state_e state;
  vdp_byte_t   latch_q;
  status_sel_t status_sel;
  vdp_byte_t   status_byte;
  reg_num_t    wr_num;
  logic        req;
  logic        port_hit;
  logic        first_wr;
  logic        reg_wr;
  logic        status_rd;

  // ----------------------------------------------------------
  // Bus decode
  // ----------------------------------------------------------
  // A new request is taken only while ack is low
  assign req      = cyc & stb & ~ack;
  assign port_hit = (adr == port_addr_t'(1));

  assign first_wr  = req & port_hit & we & (state == PORT_FIRST);
  assign status_rd = req & port_hit & ~we;

  // Second byte with bit 7 set selects a register write
  assign reg_wr = req & port_hit & we & (state == PORT_SECOND) & dat_w[7];
  assign wr_num = dat_w[5:0];

  // ----------------------------------------------------------
  // Port state and handshake
  // ----------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ack        <= 1'b0;
      state      <= PORT_FIRST;
      clr_vblank <= 1'b0;
      clr_line   <= 1'b0;
    end else begin
      ack        <= req;
      clr_vblank <= 1'b0;
      clr_line   <= 1'b0;
      if (req && port_hit) begin
        if (we) begin
          // Second byte, register write or address setup
          if (state == PORT_FIRST) begin
            state <= PORT_SECOND;
          end else begin
            state <= PORT_FIRST;
          end
        end else begin
          state      <= PORT_FIRST;
          // Reading a status register acknowledges its flag
          clr_vblank <= (status_sel == 4'd0);
          clr_line   <= (status_sel == 4'd1);
        end
      end
    end
  end

  // First byte holds the data for the next register write
  always_ff @(posedge RESET) begin
    if (first_wr) begin
      latch_q <= dat_w;
    end
  end

  // ----------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ctrl       <= '0;
      status_sel <= '0;
    end else if (reg_wr) begin
      case (wr_num)
        REG_MODE0: begin
          ctrl.line_int_en <= latch_q[R0_IE1_BIT];
        end
        REG_MODE1: begin
          ctrl.vblank_int_en <= latch_q[R1_IE0_BIT];
        end
        REG_MODE9: begin
          ctrl.lines_212 <= latch_q[R9_LN_BIT];
          ctrl.pal_mode  <= latch_q[R9_NT_BIT];
        end
        REG_STATUS_PTR: begin
          status_sel <= latch_q[3:0];
        end
        REG_INT_LINE: begin
          ctrl.int_line <= latch_q;
        end
        default: begin
          // Register not implemented here
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Status read mux
  // ----------------------------------------------------------
  always_comb begin
    status_byte = '0;
    case (status_sel)
      4'd0: status_byte[S0_F_BIT] = flags.vblank_pend;
      4'd1: status_byte[S1_FH_BIT] = flags.line_pend;
      4'd2: begin
        status_byte[S2_VR_BIT] = beam.vblank;
        status_byte[S2_HR_BIT] = beam.hblank;
      end
      default: status_byte = 8'hFF;
    endcase
  end

  // Read data is captured with the pre-clear flag values
  always_ff @(posedge RESET) begin
    if (req && !we) begin
      if (status_rd) begin
        dat_r <= status_byte;
      end else begin
        dat_r <= 8'hFF;
      end
    end
  end

endmodule

//--- hw/vdp_pkg.sv
// ----------------------------------------------------------
// VDP shared definitions
// Frame constants, register map, bus types and signal groups
// ----------------------------------------------------------

package vdp_pkg;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  typedef logic [7:0] vdp_byte_t;
  typedef logic [8:0] dot_cnt_t;
  typedef logic [8:0] line_cnt_t;
  typedef logic [5:0] reg_num_t;
  typedef logic [3:0] status_sel_t;
  typedef logic [1:0] port_addr_t;

  // ----------------------------------------------------------
  // Frame geometry
  // ----------------------------------------------------------
  localparam dot_cnt_t  DOTS_PER_LINE    = 9'd342;
  // Horizontal blank starts at this dot
  localparam dot_cnt_t  ACTIVE_DOTS      = 9'd256;
  localparam line_cnt_t LINES_NTSC       = 9'd262;
  localparam line_cnt_t LINES_PAL        = 9'd313;
  localparam line_cnt_t ACTIVE_LINES_192 = 9'd192;
  localparam line_cnt_t ACTIVE_LINES_212 = 9'd212;

  // Kept control registers
  localparam reg_num_t REG_MODE0      = 6'd0;
  localparam reg_num_t REG_MODE1      = 6'd1;
  localparam reg_num_t REG_MODE9      = 6'd9;
  localparam reg_num_t REG_STATUS_PTR = 6'd15;
  localparam reg_num_t REG_INT_LINE   = 6'd19;

  // Control register bits
  localparam int R0_IE1_BIT = 4;
  localparam int R1_IE0_BIT = 5;
  localparam int R9_LN_BIT  = 7;
  localparam int R9_NT_BIT  = 1;

  // Status register bits
  localparam int S0_F_BIT  = 7;
  localparam int S1_FH_BIT = 0;
  localparam int S2_VR_BIT = 6;
  localparam int S2_HR_BIT = 5;

  // ----------------------------------------------------------
  // Signal groups
  // ----------------------------------------------------------
  typedef struct packed {
    logic      line_int_en;
    logic      vblank_int_en;
    logic      pal_mode;
    logic      lines_212;
    vdp_byte_t int_line;
  } vdp_ctrl_t;

  typedef struct packed {
    dot_cnt_t  dot;
    line_cnt_t line;
    logic      hblank;
    logic      vblank;
  } beam_t;

  typedef struct packed {
    logic vblank_pend;
    logic line_pend;
  } int_flags_t;

  // Two-byte control port sequence
  typedef enum logic {
    PORT_FIRST,
    PORT_SECOND
  } port_state_e;

endpackage
